// ==== src/rob_pkg.sv ====
package rob_pkg;

    // ========================================
    // Lane and port counts
    // ========================================
    localparam int alloc_lanes  = 2;  // Allocation and commit lanes
    localparam int result_lanes = 2;  // Result bus lanes
    localparam int read_ports   = 2;  // One instruction, two operands

    // ========================================
    // Tags and register numbers
    // ========================================
    localparam int tag_w = 2;

    typedef logic [tag_w-1:0] tag_t;   // Producer tag
    typedef logic [4:0]       dest_t;  // Architectural destination register

    // All ones means the data is present
    localparam tag_t tag_ready = '1;

endpackage

// ==== src/rob_ifs.sv ====
`timescale 1ns/10ps

// Allocation lanes, one write per lane into the entry store
interface rob_alloc_if import rob_pkg::*; #(
    parameter int DEPTH = 16
);
    typedef logic [$clog2(DEPTH)-1:0] rob_idx_t;

    logic     we   [alloc_lanes];  // Lane requested and whole request accepted
    rob_idx_t idx  [alloc_lanes];  // Target entry
    tag_t     tag  [alloc_lanes];
    dest_t    dest [alloc_lanes];

    modport source (output we, idx, tag, dest);
    modport sink   (input  we, idx, tag, dest);
endinterface

// Result bus, no back-pressure
interface rob_result_if import rob_pkg::*; #(
    parameter int DEPTH      = 16,
    parameter int DATA_WIDTH = 32
);
    typedef logic [$clog2(DEPTH)-1:0] rob_idx_t;
    typedef logic [DATA_WIDTH-1:0]    data_t;

    logic     valid     [result_lanes];
    rob_idx_t index     [result_lanes];
    data_t    data      [result_lanes];
    logic     exception [result_lanes];

    modport source (output valid, index, data, exception);
    modport sink   (input  valid, index, data, exception);
endinterface

// Head entries out to the commit side, retire enables back
interface rob_retire_if import rob_pkg::*; #(
    parameter int DEPTH      = 16,
    parameter int DATA_WIDTH = 32
);
    typedef logic [$clog2(DEPTH)-1:0] rob_idx_t;
    typedef logic [DATA_WIDTH-1:0]    data_t;

    rob_idx_t head_idx  [alloc_lanes];  // Head and head+1
    logic     retire_en [alloc_lanes];
    logic     executed  [alloc_lanes];
    data_t    data      [alloc_lanes];
    dest_t    dest      [alloc_lanes];
    logic     exception [alloc_lanes];

    modport commit (output head_idx, retire_en, input executed, data, dest, exception);
    modport store  (input head_idx, retire_en, output executed, data, dest, exception);
endinterface

// ==== src/rob_alloc.sv ====
`timescale 1ns/10ps

module rob_alloc import rob_pkg::*; #(
    parameter int       DEPTH     = 16,
    localparam int      IDX_W     = $clog2(DEPTH),
    localparam type     rob_idx_t = logic [IDX_W-1:0],
    localparam type     rob_ptr_t = logic [IDX_W:0],
    localparam type     rob_cnt_t = logic [IDX_W:0]
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [alloc_lanes-1:0] req_valid,
    input  tag_t                   req_tag  [alloc_lanes],
    input  dest_t                  req_dest [alloc_lanes],
    input  rob_ptr_t               head_ptr,     // From the commit side
    output logic                   accept,       // Whole request taken
    output rob_cnt_t               count,
    output logic                   full,
    output logic                   empty,
    output rob_idx_t               tail_index,
    rob_alloc_if.source            alloc
);

    rob_ptr_t tail_ptr;  // Wrap bit on top
    rob_cnt_t num_req;
    rob_cnt_t free_entries;

    // ========================================
    // Occupancy and free-space check
    // ========================================
    assign count        = tail_ptr - head_ptr;  // Wrap bit keeps full apart from empty
    assign free_entries = rob_cnt_t'(DEPTH) - count;
    assign full         = (count == rob_cnt_t'(DEPTH));
    assign empty        = (count == '0);
    assign tail_index   = tail_ptr[IDX_W-1:0];

    always_comb begin
        num_req = '0;
        for (int l = 0; l < alloc_lanes; l++) begin
            num_req = num_req + rob_cnt_t'(req_valid[l]);
        end
    end

    assign accept = (free_entries >= num_req);  // All or nothing

    // Lane indices, lane 1 slides down when lane 0 is idle
    always_comb begin
        for (int l = 0; l < alloc_lanes; l++) begin
            alloc.we[l]   = req_valid[l] && accept;
            alloc.tag[l]  = req_tag[l];
            alloc.dest[l] = req_dest[l];
        end
        alloc.idx[0] = tail_index;
        alloc.idx[1] = tail_index + rob_idx_t'(alloc.we[0]);
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            tail_ptr <= '0;
        end else if (accept) begin
            tail_ptr <= tail_ptr + num_req;  // Zero when nothing requested
        end
    end

endmodule

// ==== src/rob_entry_store.sv ====
`timescale 1ns/10ps

module rob_entry_store import rob_pkg::*; #(
    parameter int   DEPTH      = 16,
    parameter int   DATA_WIDTH = 32,
    localparam type rob_idx_t  = logic [$clog2(DEPTH)-1:0],
    localparam type data_t     = logic [DATA_WIDTH-1:0]
) (
    input  logic        clk,
    input  logic        reset,
    rob_alloc_if.sink   alloc,
    rob_result_if.sink  result,
    rob_retire_if.store retire,
    input  rob_idx_t    read_index [read_ports],
    output data_t       raw_data   [read_ports],  // Before forwarding
    output tag_t        raw_tag    [read_ports]
);

    // ========================================
    // Entry fields
    // ========================================
    data_t data_q [DEPTH];
    tag_t  tag_q  [DEPTH];
    dest_t dest_q [DEPTH];
    logic  exec_q [DEPTH];  // Result written, entry may commit
    logic  exc_q  [DEPTH];

    // Later writes in the block override earlier ones
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int e = 0; e < DEPTH; e++) begin
                data_q[e] <= '0;
                tag_q[e]  <= '0;
                dest_q[e] <= '0;
                exec_q[e] <= 1'b0;
                exc_q[e]  <= 1'b0;
            end
        end else begin
            // Retired entries leave empty
            for (int l = 0; l < alloc_lanes; l++) begin
                if (retire.retire_en[l]) begin
                    data_q[retire.head_idx[l]] <= '0;
                    tag_q[retire.head_idx[l]]  <= '0;
                    dest_q[retire.head_idx[l]] <= '0;
                    exec_q[retire.head_idx[l]] <= 1'b0;
                    exc_q[retire.head_idx[l]]  <= 1'b0;
                end
            end
            // New entries, result still pending
            for (int l = 0; l < alloc_lanes; l++) begin
                if (alloc.we[l]) begin
                    data_q[alloc.idx[l]] <= '0;
                    tag_q[alloc.idx[l]]  <= alloc.tag[l];
                    dest_q[alloc.idx[l]] <= alloc.dest[l];
                    exec_q[alloc.idx[l]] <= 1'b0;
                    exc_q[alloc.idx[l]]  <= 1'b0;
                end
            end
            // Writeback, dest untouched
            for (int l = 0; l < result_lanes; l++) begin
                if (result.valid[l]) begin
                    data_q[result.index[l]] <= result.data[l];
                    tag_q[result.index[l]]  <= tag_ready;
                    exec_q[result.index[l]] <= 1'b1;
                    exc_q[result.index[l]]  <= result.exception[l];
                end
            end
        end
    end

    // ========================================
    // Lookups
    // ========================================
    always_comb begin
        for (int l = 0; l < alloc_lanes; l++) begin
            retire.executed[l]  = exec_q[retire.head_idx[l]];
            retire.data[l]      = data_q[retire.head_idx[l]];
            retire.dest[l]      = dest_q[retire.head_idx[l]];
            retire.exception[l] = exc_q[retire.head_idx[l]];
        end
        for (int p = 0; p < read_ports; p++) begin
            raw_data[p] = data_q[read_index[p]];
            raw_tag[p]  = tag_q[read_index[p]];
        end
    end

endmodule

// ==== src/rob_operand_read.sv ====
`timescale 1ns/10ps

module rob_operand_read import rob_pkg::*; #(
    parameter int   DEPTH      = 16,
    parameter int   DATA_WIDTH = 32,
    localparam type rob_idx_t  = logic [$clog2(DEPTH)-1:0],
    localparam type data_t     = logic [DATA_WIDTH-1:0]
) (
    input  rob_idx_t   read_index [read_ports],
    input  data_t      raw_data   [read_ports],
    input  tag_t       raw_tag    [read_ports],
    rob_alloc_if.sink  alloc,
    rob_result_if.sink result,
    output data_t      read_data  [read_ports],
    output tag_t       read_tag   [read_ports]
);

    // Each pass overrides the one before, so the last match has priority:
    // result lane 1, result lane 0, alloc lane 1, alloc lane 0, storage
    always_comb begin
        for (int p = 0; p < read_ports; p++) begin
            read_data[p] = raw_data[p];  // Default from storage
            read_tag[p]  = raw_tag[p];

            // ========================================
            // Same-cycle allocation
            // ========================================
            for (int l = 0; l < alloc_lanes; l++) begin
                if (alloc.we[l] && (alloc.idx[l] == read_index[p])) begin
                    read_data[p] = '0;            // Result not produced yet
                    read_tag[p]  = alloc.tag[l];
                end
            end

            // ========================================
            // Result bus bypass
            // ========================================
            for (int l = 0; l < result_lanes; l++) begin
                if (result.valid[l] && (result.index[l] == read_index[p])) begin
                    read_data[p] = result.data[l];
                    read_tag[p]  = tag_ready;
                end
            end
        end
    end

endmodule

// ==== src/rob_commit.sv ====
`timescale 1ns/10ps

module rob_commit import rob_pkg::*; #(
    parameter int   DEPTH      = 16,
    parameter int   DATA_WIDTH = 32,
    localparam int  IDX_W      = $clog2(DEPTH),
    localparam type rob_idx_t  = logic [IDX_W-1:0],
    localparam type rob_ptr_t  = logic [IDX_W:0],
    localparam type rob_cnt_t  = logic [IDX_W:0],
    localparam type data_t     = logic [DATA_WIDTH-1:0]
) (
    input  logic          clk,
    input  logic          reset,
    input  rob_cnt_t      count,                          // Occupancy from the alloc side
    rob_retire_if.commit  retire,
    output rob_ptr_t      head_ptr,
    output rob_idx_t      head_index,
    output logic          commit_ready     [alloc_lanes],
    output data_t         commit_data      [alloc_lanes],
    output dest_t         commit_dest      [alloc_lanes],
    output logic          commit_exception [alloc_lanes]
);

    rob_ptr_t num_commit;

    assign head_index = head_ptr[IDX_W-1:0];

    // ========================================
    // Head entries and readiness
    // ========================================
    always_comb begin
        retire.head_idx[0] = head_index;
        retire.head_idx[1] = head_index + rob_idx_t'(1);  // Wraps with power-of-two depth

        // Strictly in order, lane 1 needs lane 0
        commit_ready[0] = (count >= rob_cnt_t'(1)) && retire.executed[0];
        commit_ready[1] = commit_ready[0] && (count >= rob_cnt_t'(2))
                          && retire.executed[1];

        num_commit = '0;
        for (int l = 0; l < alloc_lanes; l++) begin
            retire.retire_en[l] = commit_ready[l];  // Outside never stalls commit
            commit_data[l]      = retire.data[l];
            commit_dest[l]      = retire.dest[l];
            commit_exception[l] = retire.exception[l];
            num_commit          = num_commit + rob_ptr_t'(commit_ready[l]);
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            head_ptr <= '0;
        end else begin
            head_ptr <= head_ptr + num_commit;
        end
    end

endmodule

// ==== src/reorder_buffer.sv ====
`timescale 1ns/10ps

module reorder_buffer import rob_pkg::*; #(
    parameter int   DEPTH      = 16,  // Power of two
    parameter int   DATA_WIDTH = 32,
    localparam int  IDX_W      = $clog2(DEPTH),
    localparam type rob_idx_t  = logic [IDX_W-1:0],
    localparam type rob_ptr_t  = logic [IDX_W:0],
    localparam type rob_cnt_t  = logic [IDX_W:0],
    localparam type data_t     = logic [DATA_WIDTH-1:0]
) (
    input  logic     clk,
    input  logic     reset,
    // Allocation
    input  logic     alloc_valid_0,
    input  logic     alloc_valid_1,
    input  tag_t     alloc_tag_0,
    input  tag_t     alloc_tag_1,
    input  dest_t    alloc_dest_0,
    input  dest_t    alloc_dest_1,
    output logic     alloc_accept,
    // Result bus
    input  logic     result_valid_0,
    input  logic     result_valid_1,
    input  rob_idx_t result_index_0,
    input  rob_idx_t result_index_1,
    input  data_t    result_data_0,
    input  data_t    result_data_1,
    input  logic     result_exception_0,
    input  logic     result_exception_1,
    // Operand reads
    input  rob_idx_t read_index_0,
    input  rob_idx_t read_index_1,
    output data_t    read_data_0,
    output data_t    read_data_1,
    output tag_t     read_tag_0,
    output tag_t     read_tag_1,
    // Commit
    output logic     commit_ready_0,
    output logic     commit_ready_1,
    output data_t    commit_data_0,
    output data_t    commit_data_1,
    output dest_t    commit_dest_0,
    output dest_t    commit_dest_1,
    output logic     commit_exception_0,
    output logic     commit_exception_1,
    // Status
    output rob_cnt_t count,
    output logic     full,
    output logic     empty,
    output rob_idx_t head_index,
    output rob_idx_t tail_index
);

    rob_alloc_if  #(.DEPTH(DEPTH))                           alloc_bus ();
    rob_result_if #(.DEPTH(DEPTH), .DATA_WIDTH(DATA_WIDTH)) result_bus ();
    rob_retire_if #(.DEPTH(DEPTH), .DATA_WIDTH(DATA_WIDTH)) retire_bus ();

    rob_ptr_t head_ptr;
    tag_t     req_tag   [alloc_lanes];
    dest_t    req_dest  [alloc_lanes];
    rob_idx_t rd_index  [read_ports];
    data_t    raw_data  [read_ports];
    tag_t     raw_tag   [read_ports];
    data_t    rd_data   [read_ports];
    tag_t     rd_tag    [read_ports];
    logic     c_ready   [alloc_lanes];
    data_t    c_data    [alloc_lanes];
    dest_t    c_dest    [alloc_lanes];
    logic     c_exc     [alloc_lanes];

    // ========================================
    // Ports into lane arrays
    // ========================================
    assign req_tag[0]  = alloc_tag_0;
    assign req_tag[1]  = alloc_tag_1;
    assign req_dest[0] = alloc_dest_0;
    assign req_dest[1] = alloc_dest_1;
    assign rd_index[0] = read_index_0;
    assign rd_index[1] = read_index_1;

    assign result_bus.valid[0]     = result_valid_0;
    assign result_bus.valid[1]     = result_valid_1;
    assign result_bus.index[0]     = result_index_0;
    assign result_bus.index[1]     = result_index_1;
    assign result_bus.data[0]      = result_data_0;
    assign result_bus.data[1]      = result_data_1;
    assign result_bus.exception[0] = result_exception_0;
    assign result_bus.exception[1] = result_exception_1;

    rob_alloc #(.DEPTH(DEPTH)) u_alloc (
        .clk        (clk),
        .reset      (reset),
        .req_valid  ({alloc_valid_1, alloc_valid_0}),
        .req_tag    (req_tag),
        .req_dest   (req_dest),
        .head_ptr   (head_ptr),
        .accept     (alloc_accept),
        .count      (count),
        .full       (full),
        .empty      (empty),
        .tail_index (tail_index),
        .alloc      (alloc_bus.source)
    );

    rob_entry_store #(.DEPTH(DEPTH), .DATA_WIDTH(DATA_WIDTH)) u_store (
        .clk        (clk),
        .reset      (reset),
        .alloc      (alloc_bus.sink),
        .result     (result_bus.sink),
        .retire     (retire_bus.store),
        .read_index (rd_index),
        .raw_data   (raw_data),
        .raw_tag    (raw_tag)
    );

    rob_operand_read #(.DEPTH(DEPTH), .DATA_WIDTH(DATA_WIDTH)) u_read (
        .read_index (rd_index),
        .raw_data   (raw_data),
        .raw_tag    (raw_tag),
        .alloc      (alloc_bus.sink),
        .result     (result_bus.sink),
        .read_data  (rd_data),
        .read_tag   (rd_tag)
    );

    rob_commit #(.DEPTH(DEPTH), .DATA_WIDTH(DATA_WIDTH)) u_commit (
        .clk              (clk),
        .reset            (reset),
        .count            (count),
        .retire           (retire_bus.commit),
        .head_ptr         (head_ptr),
        .head_index       (head_index),
        .commit_ready     (c_ready),
        .commit_data      (c_data),
        .commit_dest      (c_dest),
        .commit_exception (c_exc)
    );

    // ========================================
    // Lane arrays back out to ports
    // ========================================
    assign read_data_0        = rd_data[0];
    assign read_data_1        = rd_data[1];
    assign read_tag_0         = rd_tag[0];
    assign read_tag_1         = rd_tag[1];
    assign commit_ready_0     = c_ready[0];
    assign commit_ready_1     = c_ready[1];
    assign commit_data_0      = c_data[0];
    assign commit_data_1      = c_data[1];
    assign commit_dest_0      = c_dest[0];
    assign commit_dest_1      = c_dest[1];
    assign commit_exception_0 = c_exc[0];
    assign commit_exception_1 = c_exc[1];

endmodule

// ==== tb/reorder_buffer_asserts.sv ====
`timescale 1ns/10ps

module reorder_buffer_asserts #(
    parameter int DEPTH       = 16,
    parameter bit CHECK_FLAGS = 1'b1,         // Occupancy rules
    parameter bit CHECK_LANES = 1'b1          // Commit lane ordering
) (
    input logic                   clk,
    input logic                   reset,
    input logic [$clog2(DEPTH):0] count,
    input logic                   full,
    input logic                   empty,
    input logic                   ready_0,    // Commit lanes
    input logic                   ready_1
);

    localparam int             CW        = $clog2(DEPTH) + 1;
    localparam logic [CW-1:0]  max_count = CW'(DEPTH);

    int fail_count = 0;                       // Failures seen in this instance

    // ========================================
    // Occupancy rules
    // ========================================
    if (CHECK_FLAGS) begin : g_flags
        count_in_range: assert property (@(posedge clk) disable iff (!reset)
            count <= max_count)
            else begin
                $error("count is above the buffer depth");
                fail_count++;
            end

        full_not_empty: assert property (@(posedge clk) disable iff (!reset)
            !(full && empty))
            else begin
                $error("full and empty are high together");
                fail_count++;
            end
    end

    // ========================================
    // Ordering rules
    // ========================================
    if (CHECK_LANES) begin : g_lanes
        lane1_needs_lane0: assert property (@(posedge clk) disable iff (!reset)
            ready_1 |-> ready_0)
            else begin
                $error("commit lane 1 is ready without lane 0");
                fail_count++;
            end
    end

endmodule

// Alloc side owns count, full and empty
bind rob_alloc reorder_buffer_asserts #(
    .DEPTH       (DEPTH),
    .CHECK_FLAGS (1'b1),
    .CHECK_LANES (1'b0)
) alloc_chk (
    .clk     (clk),
    .reset   (reset),
    .count   (count),
    .full    (full),
    .empty   (empty),
    .ready_0 (1'b0),
    .ready_1 (1'b0)
);

// Commit side owns the ready lanes
bind rob_commit reorder_buffer_asserts #(
    .DEPTH       (DEPTH),
    .CHECK_FLAGS (1'b0),
    .CHECK_LANES (1'b1)
) commit_chk (
    .clk     (clk),
    .reset   (reset),
    .count   (count),
    .full    (1'b0),
    .empty   (1'b0),
    .ready_0 (commit_ready[0]),
    .ready_1 (commit_ready[1])
);

// ==== tb/tb_reorder_buffer.sv ====
`timescale 1ns/10ps

module tb_reorder_buffer import rob_pkg::*; ();

    localparam int DEPTH      = 16;
    localparam int DATA_WIDTH = 32;
    localparam int IDX_W      = $clog2(DEPTH);

    typedef logic [IDX_W-1:0]      idx_t;
    typedef logic [DATA_WIDTH-1:0] word_t;

    // One line of the vector file, inputs then expected outputs
    typedef struct packed {
        logic [31:0] av, at, ad0, ad1, rv, ri0, ri1, rd0, rd1, re, xi0, xi1;
        logic [31:0] acc, ro0, ro1, rt, cr, cd0, cd1, cs0, cs1, ce, cnt, fe, hd, tl;
    } vec_t;

    logic           clk = 1'b0;
    logic           reset;
    logic           alloc_valid_0, alloc_valid_1, alloc_accept;
    tag_t           alloc_tag_0, alloc_tag_1, read_tag_0, read_tag_1;
    dest_t          alloc_dest_0, alloc_dest_1, commit_dest_0, commit_dest_1;
    logic           result_valid_0, result_valid_1, result_exception_0, result_exception_1;
    idx_t           result_index_0, result_index_1, read_index_0, read_index_1;
    word_t          result_data_0, result_data_1, read_data_0, read_data_1;
    logic           commit_ready_0, commit_ready_1, commit_exception_0, commit_exception_1;
    word_t          commit_data_0, commit_data_1;
    logic [IDX_W:0] count;                      // Occupancy, wrap bit wide
    logic           full, empty;
    idx_t           head_index, tail_index;

    vec_t vectors[$];
    int   errors       = 0;
    int   vec_num      = 0;                    // Vector being checked
    int   cycle_count  = 0;
    int   cycle_limit  = 1000;                 // Reset once the vectors are loaded
    int   assert_fails = 0;

    reorder_buffer dut0 (.*);                  // Default DEPTH and DATA_WIDTH

    always #2 clk = ~clk;                      // 4 ns period

    // ========================================
    // Vector file and stimulus
    // ========================================
    task automatic init_inputs();
        vec_t zero_vec;
        zero_vec = '0;
        reset    = 1'b0;                       // Held through the first two cycles
        drive_inputs(zero_vec);
    endtask

    task automatic load_vectors();
        int    fd;
        int    n;
        string line;
        vec_t  v;
        fd = $fopen("tb/rob_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open the vector file tb/rob_tests.txt");
            errors++;
        end else begin
            while ($fgets(line, fd)) begin
                n = $sscanf(line,
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    v.av, v.at, v.ad0, v.ad1, v.rv, v.ri0, v.ri1, v.rd0, v.rd1, v.re,
                    v.xi0, v.xi1, v.acc, v.ro0, v.ro1, v.rt, v.cr, v.cd0, v.cd1,
                    v.cs0, v.cs1, v.ce, v.cnt, v.fe, v.hd, v.tl);
                if (n == 26) begin
                    vectors.push_back(v);
                end else if (n > 0) begin
                    $display("vector line has %0d fields instead of 26: %s", n, line);
                    errors++;
                end                            // Comment and blank lines scan as nothing
            end
            $fclose(fd);
            if (vectors.size() == 0) begin
                $display("the vector file holds no test vectors");
                errors++;
            end
        end
    endtask

    task automatic drive_inputs(input vec_t v);
        alloc_valid_0      = v.av[0];          // Lane pairs packed as lane 1 over lane 0
        alloc_valid_1      = v.av[1];
        alloc_tag_0        = v.at[tag_w-1:0];
        alloc_tag_1        = v.at[2*tag_w-1:tag_w];
        alloc_dest_0       = v.ad0[4:0];
        alloc_dest_1       = v.ad1[4:0];
        result_valid_0     = v.rv[0];
        result_valid_1     = v.rv[1];
        result_index_0     = v.ri0[IDX_W-1:0];
        result_index_1     = v.ri1[IDX_W-1:0];
        result_data_0      = v.rd0;
        result_data_1      = v.rd1;
        result_exception_0 = v.re[0];
        result_exception_1 = v.re[1];
        read_index_0       = v.xi0[IDX_W-1:0];
        read_index_1       = v.xi1[IDX_W-1:0];
    endtask

    // ========================================
    // Checks
    // ========================================
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("mismatch %s in vector %0d: expected %h, got %h",
                     name, vec_num, expected, actual);
            errors++;
        end
    endtask

    task automatic check_outputs(input vec_t v);
        check_value("alloc_accept", v.acc, 32'(alloc_accept));
        check_value("read_data_0", v.ro0, 32'(read_data_0));
        check_value("read_data_1", v.ro1, 32'(read_data_1));
        check_value("read_tag_0", 32'(v.rt[tag_w-1:0]), 32'(read_tag_0));
        check_value("read_tag_1", 32'(v.rt[2*tag_w-1:tag_w]), 32'(read_tag_1));
        check_value("commit_ready_0", 32'(v.cr[0]), 32'(commit_ready_0));
        check_value("commit_ready_1", 32'(v.cr[1]), 32'(commit_ready_1));
        check_value("commit_data_0", v.cd0, 32'(commit_data_0));
        check_value("commit_data_1", v.cd1, 32'(commit_data_1));
        check_value("commit_dest_0", v.cs0, 32'(commit_dest_0));
        check_value("commit_dest_1", v.cs1, 32'(commit_dest_1));
        check_value("commit_exception_0", 32'(v.ce[0]), 32'(commit_exception_0));
        check_value("commit_exception_1", 32'(v.ce[1]), 32'(commit_exception_1));
        check_value("count", v.cnt, 32'(count));
        check_value("full", 32'(v.fe[1]), 32'(full));
        check_value("empty", 32'(v.fe[0]), 32'(empty));
        check_value("head_index", v.hd, 32'(head_index));
        check_value("tail_index", v.tl, 32'(tail_index));
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        init_inputs();
        load_vectors();
        cycle_limit = vectors.size() + 20;
        repeat (2) @(posedge clk);
        #1 reset = 1'b1;
        foreach (vectors[i]) begin
            vec_num = i;
            drive_inputs(vectors[i]);          // Edge plus 1 ns
            #2.5;
            check_outputs(vectors[i]);         // Just before the next edge
            @(posedge clk);
            #1;
        end
        assert_fails = dut0.u_alloc.alloc_chk.fail_count
                     + dut0.u_commit.commit_chk.fail_count;
        $display("Vector check errors: %0d, assertion failures: %0d", errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Run limit, counted from time zero
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            errors++;
            $display("timeout after %0d cycles, vectors did not finish", cycle_limit);
            $display("Vector check errors: %0d", errors);
            $display("Finished with errors");
            $finish;
        end
    end

endmodule

// ==== tb/rob_tests.txt ====
# in:  av at ad0 ad1 rv ri0 ri1 rd0 rd1 re xi0 xi1  (pairs packed lane1:lane0, tags 2 bits each)
# out: acc ro0 ro1 rt cr cd0 cd1 cs0 cs1 ce cnt fe hd tl  (fe is full:empty)
0 0 00 00 0 0 0 00 00 0 0 0    1 00 00 0 0 00 00 00 00 0 00 1 0 0
3 9 03 04 0 0 0 00 00 0 0 1    1 00 00 9 0 00 00 00 00 0 00 1 0 0
2 c 00 05 0 0 0 00 00 0 2 0    1 00 00 7 0 00 00 03 04 0 02 0 0 2
0 0 00 00 3 1 2 22 33 2 1 2    1 22 33 f 0 00 00 03 04 0 03 0 0 3
0 0 00 00 0 0 0 00 00 0 1 2    1 22 33 f 0 00 22 03 04 0 03 0 0 3
0 0 00 00 3 0 0 11 44 0 0 1    1 44 22 f 0 00 22 03 04 0 03 0 0 3
3 5 06 07 0 0 0 00 00 0 0 1    1 44 22 f 3 44 22 03 04 0 03 0 0 3
0 0 00 00 0 0 0 00 00 0 0 1    1 00 00 0 1 33 00 05 06 1 03 0 2 5
0 0 00 00 3 4 3 66 55 2 2 3    1 00 55 c 0 00 00 06 07 0 02 0 3 5
0 0 00 00 0 0 0 00 00 0 3 4    1 55 66 f 3 55 66 06 07 1 02 0 3 5
3 9 08 09 0 0 0 00 00 0 5 6    1 00 00 9 0 00 00 00 00 0 00 1 5 5
3 9 0a 0b 0 0 0 00 00 0 0 1    1 00 00 0 0 00 00 08 09 0 02 0 5 7
3 9 0c 0d 0 0 0 00 00 0 0 1    1 00 00 0 0 00 00 08 09 0 04 0 5 9
3 9 0e 0f 0 0 0 00 00 0 0 1    1 00 00 0 0 00 00 08 09 0 06 0 5 b
3 9 10 11 0 0 0 00 00 0 0 1    1 00 00 0 0 00 00 08 09 0 08 0 5 d
3 9 12 13 0 0 0 00 00 0 0 1    1 00 00 2 0 00 00 08 09 0 0a 0 5 f
3 9 14 15 0 0 0 00 00 0 0 1    1 00 00 6 0 00 00 08 09 0 0c 0 5 1
3 9 16 17 0 0 0 00 00 0 0 1    1 00 00 6 0 00 00 08 09 0 0e 0 5 3
3 f 1e 1f 0 0 0 00 00 0 0 1    0 00 00 6 0 00 00 08 09 0 10 2 5 5
1 f 1e 1f 0 0 0 00 00 0 0 1    0 00 00 6 0 00 00 08 09 0 10 2 5 5
0 0 00 00 1 5 0 77 00 0 5 6    1 77 00 b 0 00 00 08 09 0 10 2 5 5
3 f 1e 1f 0 0 0 00 00 0 0 1    0 00 00 6 1 77 00 08 09 0 10 2 5 5
3 f 1e 1f 0 0 0 00 00 0 5 0    0 00 00 8 0 00 00 09 0a 0 0f 0 6 5
1 3 1e 00 0 0 0 00 00 0 5 0    1 00 00 b 0 00 00 09 0a 0 0f 0 6 5
0 0 00 00 3 6 7 88 99 2 6 7    1 88 99 f 0 00 00 09 0a 0 10 2 6 6
0 0 00 00 0 0 0 00 00 0 6 7    1 88 99 f 3 88 99 09 0a 2 10 2 6 6
0 0 00 00 0 0 0 00 00 0 6 7    1 00 00 0 0 00 00 0b 0c 0 0e 0 8 6

// ==== reorder_buffer.f ====
src/rob_pkg.sv
src/rob_ifs.sv
src/rob_alloc.sv
src/rob_entry_store.sv
src/rob_operand_read.sv
src/rob_commit.sv
src/reorder_buffer.sv
tb/reorder_buffer_asserts.sv
tb/tb_reorder_buffer.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the reorder buffer testbench with Verilator

log=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_reorder_buffer \
    -f reorder_buffer.f \
    -o tb_reorder_buffer
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Keep running past assertion errors so the testbench prints its verdict
./obj_dir/tb_reorder_buffer +verilator+error+limit+100 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Finished with no errors$" "$log"; then
    exit 0
fi
exit 1
